/* common/ntm_params.svh */
`ifndef NTM_PARAMS_SVH
`define NTM_PARAMS_SVH

//////////////////////////////
// Fixed point format
//////////////////////////////

// Q8.8 word, signed
`define NTM_DATA_WIDTH 16

// Fraction bits dropped after each multiply
`define NTM_FRAC_BITS 8

//////////////////////////////
// Read head sizing
//////////////////////////////

// Weight buffer depth, largest N accepted
`define NTM_MAX_N 16

// Width of the SIZE_N_IN and SIZE_W_IN inputs
`define NTM_SIZE_WIDTH 8

// Columns per run limited only by the size width
// N also limited by NTM_MAX_N

`endif

/* common/ntm_types_pkg.sv */
`include "ntm_params.svh"

package ntm_types_pkg;

  // Data word in Q8.8
  typedef logic signed [`NTM_DATA_WIDTH-1:0] ntm_word_t;

  // Full product before the fraction shift
  typedef logic signed [2*`NTM_DATA_WIDTH-1:0] ntm_prod_t;

  // N or W size as given at START
  typedef logic [`NTM_SIZE_WIDTH-1:0] ntm_size_t;

  // Index j into the weight buffer
  typedef logic [$clog2(`NTM_MAX_N)-1:0] ntm_addr_t;

endpackage

/* common/ntm_ctrl_pkg.sv */
package ntm_ctrl_pkg;

  // Read head controller states
  // IDLE      waiting for START, READY high
  // LOAD_W    taking N weight beats into the buffer
  // STREAM_M  taking W columns of N memory beats
  // DRAIN     two cycles for multiplier and summation to empty
  typedef enum logic [1:0] {
    IDLE     = 2'd0,
    LOAD_W   = 2'd1,
    STREAM_M = 2'd2,
    DRAIN    = 2'd3
  } ntm_read_state_t;

endpackage

/* hw/ntm_read_ctrl.sv */
`timescale 1ns/1ns

`include "ntm_params.svh"

module ntm_read_ctrl
  import ntm_types_pkg::*;
  import ntm_ctrl_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,

  input  logic      START,
  input  logic      W_IN_ENABLE,
  input  logic      M_IN_ENABLE,
  input  ntm_size_t SIZE_N_IN,
  input  ntm_size_t SIZE_W_IN,
  output logic      READY,

  // Weight buffer side
  output logic      wr_en,
  output ntm_addr_t wr_addr,
  output ntm_addr_t rd_addr,

  // Multiplier side
  output logic      mul_valid,
  output logic      mul_last
);

  //////////////////////////////
  // State and counters
  //////////////////////////////

  ntm_read_state_t state;

  // Last j and last k of the current run
  ntm_addr_t n_last;
  ntm_size_t w_last;

  // j steps through weights, then through each column
  ntm_addr_t j_cnt;
  ntm_size_t k_cnt;

  // Two drain cycles
  logic      drain_cnt;

  logic      j_at_end;

  assign j_at_end = (j_cnt == n_last);

  //////////////////////////////
  // Strobes
  //////////////////////////////

  assign READY = (state == IDLE);

  // Weight beats only count while loading
  assign wr_en   = (state == LOAD_W) && W_IN_ENABLE;
  assign wr_addr = j_cnt;

  // Buffer read follows j during the stream
  assign rd_addr = j_cnt;

  // M beats outside STREAM_M are dropped here
  assign mul_valid = (state == STREAM_M) && M_IN_ENABLE;
  assign mul_last  = mul_valid && j_at_end;

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= IDLE;
      n_last    <= '0;
      w_last    <= '0;
      j_cnt     <= '0;
      k_cnt     <= '0;
      drain_cnt <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          // Sizes sampled with the START pulse
          if (START) begin
            n_last <= ntm_addr_t'(SIZE_N_IN - 8'd1);
            w_last <= SIZE_W_IN - 8'd1;
            j_cnt  <= '0;
            k_cnt  <= '0;
            state  <= LOAD_W;
          end
        end

        LOAD_W: begin
          if (wr_en) begin
            if (j_at_end) begin
              // All N weights held, rewind j for column 0
              j_cnt <= '0;
              state <= STREAM_M;
            end else begin
              j_cnt <= j_cnt + 1'b1;
            end
          end
        end

        STREAM_M: begin
          if (mul_valid) begin
            if (j_at_end) begin
              j_cnt <= '0;
              // Last column closes the stream
              if (k_cnt == w_last) begin
                drain_cnt <= 1'b0;
                state     <= DRAIN;
              end else begin
                k_cnt <= k_cnt + 8'd1;
              end
            end else begin
              j_cnt <= j_cnt + 1'b1;
            end
          end
        end

        DRAIN: begin
          // Product and sum stages empty after two cycles
          if (drain_cnt) begin
            state <= IDLE;
          end
          drain_cnt <= 1'b1;
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Accepted START carries usable sizes
  assert property (@(posedge CLK) disable iff (RST)
    (START && READY) |->
      (SIZE_N_IN != '0) && (SIZE_N_IN <= `NTM_MAX_N) && (SIZE_W_IN != '0));

  // Column end only on a real M beat
  assert property (@(posedge CLK) disable iff (RST)
    mul_last |-> mul_valid);

endmodule

/* hw/ntm_weight_buffer.sv */
`timescale 1ns/1ns

`include "ntm_params.svh"

module ntm_weight_buffer
  import ntm_types_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,

  input  logic      wr_en,
  input  ntm_addr_t wr_addr,
  input  ntm_word_t wr_data,

  input  ntm_addr_t rd_addr,
  output ntm_word_t rd_data
);

  //////////////////////////////
  // Weight storage
  //////////////////////////////

  // One w(j) per entry, reused by every column
  ntm_word_t w_mem [`NTM_MAX_N];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < `NTM_MAX_N; i++) begin
        w_mem[i] <= '0;
      end
    end else if (wr_en) begin
      w_mem[wr_addr] <= wr_data;
    end
  end

  // Combinational read, lines up with the M beat
  assign rd_data = w_mem[rd_addr];

endmodule

/* hw/ntm_vector_multiplier.sv */
`timescale 1ns/1ns

`include "ntm_params.svh"

module ntm_vector_multiplier
  import ntm_types_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,

  input  logic      in_valid,
  input  logic      in_last,
  input  ntm_word_t weight,
  input  ntm_word_t mem,

  output ntm_word_t prod,
  output logic      prod_valid,
  output logic      prod_last
);

  //////////////////////////////
  // Q8.8 multiply
  //////////////////////////////

  ntm_prod_t full_prod;
  ntm_prod_t shifted_prod;

  // Signed 16 x 16 into 32
  assign full_prod = weight * mem;

  // Back to Q8.8, sign kept by arithmetic shift
  assign shifted_prod = full_prod >>> `NTM_FRAC_BITS;

  // Product word, low 16 bits of the shifted value
  always_ff @(posedge CLK) begin
    if (in_valid) begin
      prod <= ntm_word_t'(shifted_prod);
    end
  end

  // Flags travel with the product
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      prod_valid <= 1'b0;
      prod_last  <= 1'b0;
    end else begin
      prod_valid <= in_valid;
      prod_last  <= in_valid && in_last;
    end
  end

  // Column end never on an empty slot
  assert property (@(posedge CLK) disable iff (RST)
    prod_last |-> prod_valid);

endmodule

/* hw/ntm_vector_summation.sv */
`timescale 1ns/1ns

`include "ntm_params.svh"

module ntm_vector_summation
  import ntm_types_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,

  input  logic      in_valid,
  input  logic      in_last,
  input  ntm_word_t data_in,

  output ntm_word_t sum_out,
  output logic      sum_valid
);

  //////////////////////////////
  // Column accumulator
  //////////////////////////////

  // Running sum of the current column
  ntm_word_t acc;
  ntm_word_t acc_next;

  // Wraps modulo 2^16
  assign acc_next = acc + data_in;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc       <= '0;
      sum_out   <= '0;
      sum_valid <= 1'b0;
    end else begin
      // Pulse by default
      sum_valid <= 1'b0;
      if (in_valid) begin
        if (in_last) begin
          // r(k) out, next column from zero
          sum_out   <= acc_next;
          sum_valid <= 1'b1;
          acc       <= '0;
        end else begin
          acc <= acc_next;
        end
      end
    end
  end

endmodule

/* hw/ntm_reading.sv */
`timescale 1ns/1ns

`include "ntm_params.svh"

module ntm_reading
  import ntm_types_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,

  // Control
  input  logic      START,
  output logic      READY,
  input  logic      W_IN_ENABLE,
  input  logic      M_IN_ENABLE,
  output logic      R_OUT_ENABLE,

  // Data
  input  ntm_size_t SIZE_N_IN,
  input  ntm_size_t SIZE_W_IN,
  input  ntm_word_t W_IN,
  input  ntm_word_t M_IN,
  output ntm_word_t R_OUT
);

  //////////////////////////////
  // Internal wires
  //////////////////////////////

  // Controller to weight buffer
  logic      wr_en;
  ntm_addr_t wr_addr;
  ntm_addr_t rd_addr;

  // Weight w(j) for the current M beat
  ntm_word_t w_rd_data;

  // Controller to multiplier
  logic      mul_valid;
  logic      mul_last;

  // Multiplier to summation
  ntm_word_t prod;
  logic      prod_valid;
  logic      prod_last;

  //////////////////////////////
  // Instances
  //////////////////////////////

  // r(k) = sum over j of w(j) * M(j,k)
  ntm_read_ctrl u_ntm_read_ctrl (
    .CLK         (CLK),
    .RST         (RST),
    .START       (START),
    .W_IN_ENABLE (W_IN_ENABLE),
    .M_IN_ENABLE (M_IN_ENABLE),
    .SIZE_N_IN   (SIZE_N_IN),
    .SIZE_W_IN   (SIZE_W_IN),
    .READY       (READY),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .rd_addr     (rd_addr),
    .mul_valid   (mul_valid),
    .mul_last    (mul_last)
  );

  // W_IN goes straight in on its strobe
  ntm_weight_buffer u_ntm_weight_buffer (
    .CLK     (CLK),
    .RST     (RST),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (W_IN),
    .rd_addr (rd_addr),
    .rd_data (w_rd_data)
  );

  // Stage 1, product
  ntm_vector_multiplier u_ntm_vector_multiplier (
    .CLK        (CLK),
    .RST        (RST),
    .in_valid   (mul_valid),
    .in_last    (mul_last),
    .weight     (w_rd_data),
    .mem        (M_IN),
    .prod       (prod),
    .prod_valid (prod_valid),
    .prod_last  (prod_last)
  );

  // Stage 2, column sum drives the outputs
  ntm_vector_summation u_ntm_vector_summation (
    .CLK       (CLK),
    .RST       (RST),
    .in_valid  (prod_valid),
    .in_last   (prod_last),
    .data_in   (prod),
    .sum_out   (R_OUT),
    .sum_valid (R_OUT_ENABLE)
  );

endmodule

/* verification/tb_ntm_reading.sv */
`timescale 1ns/1ns

`include "ntm_params.svh"

module tb_ntm_reading
  import ntm_types_pkg::*;
;

  //////////////////////////////
  // Limits and bookkeeping
  //////////////////////////////

  localparam int MAX_N     = `NTM_MAX_N;
  localparam int MAX_COLS  = 8;
  localparam int MAX_GAP   = 2;
  // Worst run, weights plus all columns, every beat with its longest gap
  localparam int RUN_MAX   = (MAX_N + MAX_N * MAX_COLS) * (MAX_GAP + 1) + 20;
  localparam int NUM_RUNS  = 8;
  localparam int WATCHDOG_CYCLES = 2 * NUM_RUNS * RUN_MAX + 10;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic      CLK = 1'b0;
  logic      RST;
  logic      START;
  logic      W_IN_ENABLE;
  logic      M_IN_ENABLE;
  ntm_size_t SIZE_N_IN;
  ntm_size_t SIZE_W_IN;
  ntm_word_t W_IN;
  ntm_word_t M_IN;
  logic      READY;
  logic      R_OUT_ENABLE;
  ntm_word_t R_OUT;

  // Marks the M beat that closes a column
  logic      m_last_mark;

  int        cyc = 0;
  int        n_checks = 0;
  int        n_errors = 0;
  int        n_timeouts = 0;
  logic [31:0] lfsr_state = 32'd66119;

  // Stimulus for the current run
  ntm_word_t w_vec [MAX_N];
  ntm_word_t m_mat [MAX_N * MAX_COLS];

  // Observed outputs
  ntm_word_t r_val_q [$];
  int        r_cyc_q [$];
  int        last_cyc_q [$];
  int        ready_rise_cyc;
  logic      ready_d = 1'b0;

  ntm_reading u_ntm_reading (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .READY        (READY),
    .W_IN_ENABLE  (W_IN_ENABLE),
    .M_IN_ENABLE  (M_IN_ENABLE),
    .R_OUT_ENABLE (R_OUT_ENABLE),
    .SIZE_N_IN    (SIZE_N_IN),
    .SIZE_W_IN    (SIZE_W_IN),
    .W_IN         (W_IN),
    .M_IN         (M_IN),
    .R_OUT        (R_OUT)
  );

  always #50 CLK = ~CLK;

  always @(posedge CLK) begin
    cyc <= cyc + 1;
  end

  // Outputs logged mid cycle, away from the driving edge
  always @(negedge CLK) begin
    if (m_last_mark && M_IN_ENABLE) begin
      last_cyc_q.push_back(cyc);
    end
    if (R_OUT_ENABLE) begin
      r_val_q.push_back(R_OUT);
      r_cyc_q.push_back(cyc);
    end
    if (READY && !ready_d) begin
      ready_rise_cyc = cyc;
    end
    ready_d = READY;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic lsb;
    lsb = s[0];
    s = s >> 1;
    if (lsb) begin
      s = s ^ LFSR_TAPS;
    end
    return s;
  endfunction

  // One LFSR step per bit
  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // r(k) from the Q8.8 rule, terms floored by 2^8, sum kept to 16 bits
  function automatic ntm_word_t model_read(input int n, input int k);
    int prod;
    int acc;
    acc = 0;
    for (int j = 0; j < n; j++) begin
      prod = int'(w_vec[j]) * int'(m_mat[k * MAX_N + j]);
      acc = acc + int'(ntm_word_t'(prod >>> `NTM_FRAC_BITS));
    end
    return ntm_word_t'(acc);
  endfunction

  task automatic check_value(input string what, input int got, input int exp);
    n_checks++;
    if (got != exp) begin
      n_errors++;
      $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  //////////////////////////////
  // Drivers
  //////////////////////////////

  task automatic start_run(input int n, input int w);
    r_val_q.delete();
    r_cyc_q.delete();
    last_cyc_q.delete();
    ready_rise_cyc = -1;
    @(posedge CLK);
    START     <= 1'b1;
    SIZE_N_IN <= ntm_size_t'(n);
    SIZE_W_IN <= ntm_size_t'(w);
    @(posedge CLK);
    START <= 1'b0;
    // Busy from the cycle after START
    @(negedge CLK);
    check_value("READY after START", int'(READY), 0);
  endtask

  task automatic send_weights(input int n, input int gap_max);
    int gap;
    for (int j = 0; j < n; j++) begin
      gap = (gap_max > 0) ? int'(rand_bits(2)) % (gap_max + 1) : 0;
      repeat (gap) begin
        @(posedge CLK);
        W_IN_ENABLE <= 1'b0;
      end
      @(posedge CLK);
      W_IN_ENABLE <= 1'b1;
      W_IN        <= w_vec[j];
    end
    @(posedge CLK);
    W_IN_ENABLE <= 1'b0;
  endtask

  // Column by column, j fastest
  task automatic send_matrix(input int n, input int w, input int gap_max);
    int gap;
    for (int k = 0; k < w; k++) begin
      for (int j = 0; j < n; j++) begin
        gap = (gap_max > 0) ? int'(rand_bits(2)) % (gap_max + 1) : 0;
        repeat (gap) begin
          @(posedge CLK);
          M_IN_ENABLE <= 1'b0;
          m_last_mark <= 1'b0;
        end
        @(posedge CLK);
        M_IN_ENABLE <= 1'b1;
        M_IN        <= m_mat[k * MAX_N + j];
        m_last_mark <= (j == n - 1);
      end
    end
    @(posedge CLK);
    M_IN_ENABLE <= 1'b0;
    m_last_mark <= 1'b0;
  endtask

  // START and an M beat that the DUT must drop
  task automatic poke_while_busy();
    @(posedge CLK);
    START       <= 1'b1;
    SIZE_N_IN   <= 8'd5;
    SIZE_W_IN   <= 8'd7;
    M_IN_ENABLE <= 1'b1;
    M_IN        <= 16'sh7fff;
    @(posedge CLK);
    START       <= 1'b0;
    M_IN_ENABLE <= 1'b0;
  endtask

  task automatic wait_ready(input string tag);
    int waited;
    waited = 0;
    @(negedge CLK);
    while (!READY && waited < RUN_MAX) begin
      @(negedge CLK);
      waited++;
    end
    if (!READY) begin
      n_timeouts++;
      $display("Timeout in %s: READY did not come back within %0d cycles", tag, RUN_MAX);
    end
    // Extra edge so the monitor has logged the rise
    @(negedge CLK);
  endtask

  task automatic check_results(input int n, input int w, input string tag);
    int got_n;
    got_n = r_val_q.size();
    check_value({tag, " output count"}, got_n, w);
    for (int k = 0; k < w && k < got_n; k++) begin
      check_value($sformatf("%s r(%0d)", tag, k), int'(r_val_q[k]), int'(model_read(n, k)));
      if (k < last_cyc_q.size()) begin
        check_value($sformatf("%s r(%0d) latency", tag, k), r_cyc_q[k] - last_cyc_q[k], 2);
      end
    end
    if (last_cyc_q.size() > 0) begin
      check_value({tag, " READY delay"}, ready_rise_cyc - last_cyc_q[$], 3);
    end
  endtask

  task automatic run_case(input int n, input int w, input int gap_max, input string tag);
    start_run(n, w);
    send_weights(n, gap_max);
    send_matrix(n, w, gap_max);
    wait_ready(tag);
    check_results(n, w, tag);
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_single();
    @(negedge CLK);
    check_value("READY after reset", int'(READY), 1);
    check_value("R_OUT_ENABLE after reset", int'(R_OUT_ENABLE), 0);
    check_value("R_OUT after reset", int'(R_OUT), 0);
    // 1.5 times 2.0
    w_vec[0] = 16'sh0180;
    m_mat[0] = 16'sh0200;
    run_case(1, 1, 0, "single");
    if (r_val_q.size() > 0) begin
      check_value("single r(0) by hand", int'(r_val_q[0]), 16'sh0300);
    end
  endtask

  task automatic test_small();
    for (int j = 0; j < 4; j++) begin
      w_vec[j] = ntm_word_t'((j + 1) * 256);
      for (int k = 0; k < 3; k++) begin
        m_mat[k * MAX_N + j] = ntm_word_t'((j - 2 * k) * 256);
      end
    end
    run_case(4, 3, 0, "small");
  endtask

  task automatic test_random();
    int n;
    int w;
    for (int run = 0; run < 3; run++) begin
      n = 1 + int'(rand_bits(4));
      w = 1 + int'(rand_bits(3));
      for (int i = 0; i < MAX_N; i++) begin
        w_vec[i] = ntm_word_t'(rand_bits(16));
      end
      for (int i = 0; i < MAX_N * MAX_COLS; i++) begin
        m_mat[i] = ntm_word_t'(rand_bits(16));
      end
      run_case(n, w, MAX_GAP, $sformatf("random %0d", run));
    end
  endtask

  task automatic test_busy();
    w_vec[0] = 16'sh0100;
    w_vec[1] = -16'sh0200;
    for (int i = 0; i < 2 * MAX_N; i++) begin
      m_mat[i] = ntm_word_t'((i % 7 - 3) * 128);
    end
    start_run(2, 2);
    // Dropped while loading weights
    poke_while_busy();
    send_weights(2, 0);
    send_matrix(2, 2, 0);
    // Dropped while draining
    poke_while_busy();
    wait_ready("busy");
    check_results(2, 2, "busy");
    // Nothing left from the ignored START
    repeat (3) begin
      @(negedge CLK);
      check_value("READY stays high", int'(READY), 1);
    end
    check_value("busy extra outputs", r_val_q.size(), 2);
    // Second run, fresh w and a shorter N
    w_vec[0] = 16'sh0080;
    run_case(1, 3, 0, "rerun");
  endtask

  task automatic test_full();
    for (int i = 0; i < MAX_N; i++) begin
      w_vec[i] = ntm_word_t'(rand_bits(16));
    end
    for (int i = 0; i < MAX_N * MAX_COLS; i++) begin
      m_mat[i] = ntm_word_t'(rand_bits(16));
    end
    run_case(MAX_N, 4, 1, "full");
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    RST         <= 1'b1;
    START       <= 1'b0;
    W_IN_ENABLE <= 1'b0;
    M_IN_ENABLE <= 1'b0;
    SIZE_N_IN   <= '0;
    SIZE_W_IN   <= '0;
    W_IN        <= '0;
    M_IN        <= '0;
    m_last_mark <= 1'b0;
    repeat (2) @(posedge CLK);
    RST <= 1'b0;

    $display("Test 1, single element");
    test_single();
    $display("Test 2, small 4 x 3");
    test_small();
    $display("Test 3, random sizes with gaps");
    test_random();
    $display("Test 4, inputs while busy");
    test_busy();
    $display("Test 5, full buffer depth");
    test_full();

    $display("Run finished: %0d checks, %0d errors, %0d timeouts",
             n_checks, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Bound on the whole run
  initial begin
    #(WATCHDOG_CYCLES * 100);
    $display("Watchdog: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $finish;
  end

endmodule

/* tb.f */
+incdir+common
common/ntm_types_pkg.sv
common/ntm_ctrl_pkg.sv
hw/ntm_read_ctrl.sv
hw/ntm_weight_buffer.sv
hw/ntm_vector_multiplier.sv
hw/ntm_vector_summation.sv
hw/ntm_reading.sv
verification/tb_ntm_reading.sv

/* Bender.yml */
package:
  name: ntm_reading

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/ntm_types_pkg.sv
      - common/ntm_ctrl_pkg.sv
      - hw/ntm_read_ctrl.sv
      - hw/ntm_weight_buffer.sv
      - hw/ntm_vector_multiplier.sv
      - hw/ntm_vector_summation.sv
      - hw/ntm_reading.sv

  - target: test
    include_dirs:
      - common
    files:
      - verification/tb_ntm_reading.sv
